/* logic/softusb_pkg.sv */
// shared widths, enums and CSR map for the single-clock command engine
// ram_depth_log2 must stay below ADDR_W-1 so that out-of-range checks make sense
package softusb_pkg;

	// internal word address and data path
	localparam int ADDR_W = 10;
	localparam int DATA_W = 32;
	localparam int RAM_DEPTH_LOG2 = 8;

	// opcode sits in the top nibble of the command word, address in the low bits
	localparam int CMD_OP_LSB = 28;

	// zero left invalid so a cleared command word never runs
	typedef enum logic [3:0] {
		OP_READ  = 4'h1,
		OP_WRITE = 4'h2,
		OP_ADD   = 4'h3
	} softusb_op_e;

	// picked by address bit ADDR_W-1
	typedef enum logic {
		REG_RAM   = 1'b0,
		REG_TIMER = 1'b1
	} softusb_region_e;

	typedef enum logic [2:0] {
		ST_IDLE, ST_READ, ST_MODIFY, ST_WRITE, ST_ACK, ST_DROP
	} softusb_state_e;

	// word offsets inside the CSR window
	localparam logic [9:0] CSR_CMD    = 10'd0;
	localparam logic [9:0] CSR_DATA   = 10'd1;
	localparam logic [9:0] CSR_RESULT = 10'd2;
	localparam logic [9:0] CSR_STATUS = 10'd3;

	// status register bits
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;
	localparam int STAT_ERR  = 2;

endpackage

/* logic/softusb_cmd_if.sv */
// four-phase req/ack command channel, operands hold while req is high
`timescale 1ns/1ns

interface softusb_cmd_if import softusb_pkg::*; ();

	// handshake
	logic req;
	logic ack;

	// operands, valid with req
	softusb_op_e op;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;

	// response, valid with ack
	logic [DATA_W-1:0] rdata;
	logic err;

	modport requester (output req, op, addr, wdata, input ack, rdata, err);

	modport responder (input req, op, addr, wdata, output ack, rdata, err);

	// result side only watches the channel
	modport observer (input req, ack, op, addr, wdata, rdata, err);

endinterface

/* logic/softusb_bus_if.sv */
// internal memory bus, each slave decodes its own region from the top address bit
`timescale 1ns/1ns

interface softusb_bus_if import softusb_pkg::*; ();

	// master side
	logic we;
	logic [DATA_W/8-1:0] sel;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;

	// ram data lags addr by one cycle, timer data is combinational
	logic [DATA_W-1:0] rdata_ram;
	logic [DATA_W-1:0] rdata_tmr;

	modport master (output we, sel, addr, wdata, input rdata_ram, rdata_tmr);

	modport slave (input we, sel, addr, wdata, output rdata_ram, rdata_tmr);

endinterface

/* logic/softusb_cmd_decode.sv */
// CSR writes to command requests, one command in flight at a time
// writes to CMD or DATA while busy are dropped
`timescale 1ns/1ns

module softusb_cmd_decode import softusb_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic              sys_clk_i,
	input  logic              arst_n_i,
	input  logic [13:0]       csr_a_i,
	input  logic              csr_we_i,
	input  logic [DATA_W-1:0] csr_di_i,
	softusb_cmd_if.requester  cmd
);

	logic csr_sel;
	logic cmd_wr;
	logic data_wr;
	logic req_q;
	logic busy_q;
	softusb_op_e op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;

	// window match on the upper address nibble
	assign csr_sel = (csr_a_i[13:10] == csr_addr);

	// accepted only when nothing is outstanding
	assign cmd_wr  = csr_sel & csr_we_i & (csr_a_i[9:0] == CSR_CMD) & ~busy_q;
	assign data_wr = csr_sel & csr_we_i & (csr_a_i[9:0] == CSR_DATA) & ~busy_q;

	// operand registers
	always_ff @(posedge sys_clk_i) begin
		if (data_wr)
			data_q <= csr_di_i;
		if (cmd_wr) begin
			// no opcode check here, the engine flags bad codes
			op_q   <= softusb_op_e'(csr_di_i[CMD_OP_LSB +: 4]);
			addr_q <= csr_di_i[ADDR_W-1:0];
		end
	end

	// req side of the handshake
	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q  <= 1'b0;
			busy_q <= 1'b0;
		end else if (cmd_wr) begin
			req_q  <= 1'b1;
			busy_q <= 1'b1;
		end else if (req_q && cmd.ack) begin
			// response seen, release req
			req_q <= 1'b0;
		end else if (busy_q && !req_q && !cmd.ack) begin
			// ack gone, channel free again
			busy_q <= 1'b0;
		end
	end

	assign cmd.req   = req_q;
	assign cmd.op    = op_q;
	assign cmd.addr  = addr_q;
	assign cmd.wdata = data_q;

endmodule

/* logic/softusb_engine.sv */
// executes one command on the internal bus, then answers with ack
// latency req to ack: write 2, read 3, add 5, rejected 2 cycles
`timescale 1ns/1ns

module softusb_engine import softusb_pkg::*; #(
	parameter int ram_depth_log2 = RAM_DEPTH_LOG2
) (
	input  logic             sys_clk_i,
	input  logic             arst_n_i,
	softusb_cmd_if.responder cmd,
	softusb_bus_if.master    bus
);

	localparam int unsigned RAM_WORDS = 1 << ram_depth_log2;

	softusb_state_e state_q;
	softusb_region_e region;
	logic rd_wait_q;
	logic err_q;
	logic op_bad;
	logic ram_oob;
	logic cmd_bad;
	logic [DATA_W-1:0] rd_mux;
	// read value, sum or written word, zero on error
	logic [DATA_W-1:0] data_q;

	// top address bit picks the slave
	assign region = softusb_region_e'(cmd.addr[ADDR_W-1]);

	always_comb begin
		case (region)
			REG_RAM: rd_mux = bus.rdata_ram;
			default: rd_mux = bus.rdata_tmr;
		endcase
	end

	// validity checks
	always_comb begin
		case (cmd.op)
			OP_READ, OP_WRITE: op_bad = 1'b0;
			// no read-modify-write on the counter
			OP_ADD: op_bad = (region == REG_TIMER);
			default: op_bad = 1'b1;
		endcase
	end

	assign ram_oob = (region == REG_RAM) && (32'(cmd.addr[ADDR_W-2:0]) >= RAM_WORDS);
	assign cmd_bad = op_bad | ram_oob;

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= ST_IDLE;
			rd_wait_q <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cmd.req) begin
						err_q <= cmd_bad;
						if (cmd_bad)
							state_q <= ST_DROP;
						else if (cmd.op == OP_WRITE)
							state_q <= ST_WRITE;
						else
							state_q <= ST_READ;
					end
				end
				ST_READ: begin
					// two cycles, ram data shows up in the second
					rd_wait_q <= ~rd_wait_q;
					if (rd_wait_q)
						state_q <= (cmd.op == OP_ADD) ? ST_MODIFY : ST_ACK;
				end
				ST_MODIFY: state_q <= ST_WRITE;
				ST_WRITE:  state_q <= ST_ACK;
				ST_DROP:   state_q <= ST_ACK;
				ST_ACK: begin
					// hold the response until req drops
					if (!cmd.req)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// data path follows the state
	always_ff @(posedge sys_clk_i) begin
		case (state_q)
			ST_IDLE: begin
				if (cmd.req)
					data_q <= cmd_bad ? '0 : cmd.wdata;
			end
			ST_READ: begin
				if (rd_wait_q)
					data_q <= rd_mux;
			end
			// wraps at DATA_W bits
			ST_MODIFY: data_q <= data_q + cmd.wdata;
			default:   data_q <= data_q;
		endcase
	end

	// full-word writes only
	assign bus.we    = (state_q == ST_WRITE);
	assign bus.sel   = '1;
	assign bus.addr  = cmd.addr;
	assign bus.wdata = data_q;

	assign cmd.ack   = (state_q == ST_ACK);
	assign cmd.rdata = data_q;
	assign cmd.err   = err_q;

endmodule

/* logic/softusb_result.sv */
// result capture, status and irq, CSR read data one cycle after the address
`timescale 1ns/1ns

module softusb_result import softusb_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic              sys_clk_i,
	input  logic              arst_n_i,
	input  logic [13:0]       csr_a_i,
	input  logic              csr_we_i,
	input  logic [DATA_W-1:0] csr_di_i,
	output logic [DATA_W-1:0] csr_do_o,
	output logic              irq_o,
	softusb_cmd_if.observer   cmd
);

	logic csr_sel;
	logic ack_q;
	logic ack_rise;
	logic done_q;
	logic error_q;
	logic done_clr;
	logic [DATA_W-1:0] result_q;
	logic [DATA_W-1:0] status;

	assign csr_sel  = (csr_a_i[13:10] == csr_addr);
	assign ack_rise = cmd.ack & ~ack_q;
	// write one to the done bit
	assign done_clr = csr_sel & csr_we_i & (csr_a_i[9:0] == CSR_STATUS) & csr_di_i[STAT_DONE];

	always_comb begin
		status = '0;
		status[STAT_BUSY] = cmd.req | cmd.ack;
		status[STAT_DONE] = done_q;
		status[STAT_ERR]  = error_q;
	end

	always_ff @(posedge sys_clk_i) begin
		if (ack_rise)
			result_q <= cmd.rdata;
	end

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q    <= 1'b0;
			done_q   <= 1'b0;
			error_q  <= 1'b0;
			csr_do_o <= '0;
		end else begin
			ack_q <= cmd.ack;
			// a new completion wins over a clear in the same cycle
			if (ack_rise) begin
				done_q  <= 1'b1;
				error_q <= cmd.err;
			end else if (done_clr) begin
				done_q <= 1'b0;
			end
			csr_do_o <= '0;
			if (csr_sel) begin
				case (csr_a_i[9:0])
					CSR_DATA:   csr_do_o <= cmd.wdata;
					CSR_RESULT: csr_do_o <= result_q;
					CSR_STATUS: csr_do_o <= status;
					default:    csr_do_o <= '0;
				endcase
			end
		end
	end

	// level irq, follows done
	assign irq_o = done_q;

endmodule

/* logic/softusb_ram.sv */
// single-port word RAM, read data registered, old data on read during write
`timescale 1ns/1ns

module softusb_ram import softusb_pkg::*; #(
	parameter int ram_depth_log2 = RAM_DEPTH_LOG2
) (
	input  logic          sys_clk_i,
	softusb_bus_if.slave  bus
);

	logic [DATA_W-1:0] mem [0:(1 << ram_depth_log2)-1];
	logic [ram_depth_log2-1:0] idx;
	logic ram_we;

	// low address bits index the array
	assign idx = bus.addr[ram_depth_log2-1:0];
	// shared we gated by our region
	assign ram_we = bus.we & (softusb_region_e'(bus.addr[ADDR_W-1]) == REG_RAM);

	always_ff @(posedge sys_clk_i) begin
		if (ram_we) begin
			// byte lanes
			for (int b = 0; b < DATA_W/8; b++) begin
				if (bus.sel[b])
					mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
		bus.rdata_ram <= mem[idx];
	end

endmodule

/* logic/softusb_timer.sv */
// free-running cycle counter on sys_clk, wraps at 32 bits
`timescale 1ns/1ns

module softusb_timer import softusb_pkg::*; (
	input  logic          sys_clk_i,
	input  logic          arst_n_i,
	softusb_bus_if.slave  bus
);

	logic [DATA_W-1:0] count_q;
	logic tmr_we;

	// any write in the timer region clears, data ignored
	assign tmr_we = bus.we & (softusb_region_e'(bus.addr[ADDR_W-1]) == REG_TIMER);

	always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			count_q <= '0;
		else if (tmr_we)
			count_q <= '0;
		else
			count_q <= count_q + 1'b1;
	end

	// read back without a wait state
	assign bus.rdata_tmr = count_q;

endmodule

/* logic/softusb.sv */
// command-engine host block, CSR window at csr_addr, all logic on sys_clk
// no soft core, no SIE and no external RAM port
`timescale 1ns/1ns

module softusb import softusb_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int ram_depth_log2 = RAM_DEPTH_LOG2
) (
	input  logic        sys_clk_i,
	input  logic        arst_n_i,

	// CSR port
	input  logic [13:0] csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	output logic        irq_o
);

	// decode to engine, watched by result
	softusb_cmd_if cmd_if ();
	// engine to ram and timer
	softusb_bus_if bus_if ();

	softusb_cmd_decode #(
		.csr_addr(csr_addr)
	) decode (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.cmd(cmd_if.requester)
	);

	softusb_engine #(
		.ram_depth_log2(ram_depth_log2)
	) engine (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.cmd(cmd_if.responder),
		.bus(bus_if.master)
	);

	softusb_result #(
		.csr_addr(csr_addr)
	) result (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.cmd(cmd_if.observer)
	);

	// slaves on the internal bus
	softusb_ram #(
		.ram_depth_log2(ram_depth_log2)
	) ram (
		.sys_clk_i(sys_clk_i),
		.bus(bus_if.slave)
	);

	softusb_timer timer (
		.sys_clk_i(sys_clk_i),
		.arst_n_i(arst_n_i),
		.bus(bus_if.slave)
	);

endmodule

/* verif/tb_softusb.sv */
// runs the vectors in verif/softusb_input.txt, then random RAM traffic and a busy-drop case
// at most MAX_VEC vectors, a RAM model of 256 words tracks every accepted write
`timescale 1ns/1ns

module tb_softusb import softusb_pkg::*; ();

	localparam logic [3:0] CSR_BASE = 4'h3;
	localparam int MAX_VEC = 32;
	localparam int N_RAND = 8;
	localparam int POLL_MAX = 50;

	logic sys_clk;
	logic arst_n;
	logic [13:0] csr_a;
	logic csr_we;
	logic [DATA_W-1:0] csr_di;
	logic [DATA_W-1:0] csr_do;
	logic irq;

	// four words per vector: op, addr, data, error flag
	logic [31:0] vec [0:4*MAX_VEC-1];
	logic [DATA_W-1:0] model [0:255];
	logic [DATA_W-1:0] tmr_prev;
	integer seed;
	int val_errs = 0;
	int other_errs = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int nvec;

	softusb #(
		.csr_addr(CSR_BASE),
		.ram_depth_log2(RAM_DEPTH_LOG2)
	) dut_i (
		.sys_clk_i(sys_clk),
		.arst_n_i(arst_n),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_di_i(csr_di),
		.csr_do_o(csr_do),
		.irq_o(irq)
	);

	initial sys_clk = 1'b0;
	always #50 sys_clk = ~sys_clk;

	// run limit, set once the vector count is known
	always @(posedge sys_clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("run stopped after %0d cycles, the DUT stopped answering", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_status(input logic exp_busy, input logic exp_done,
			input logic exp_err, input logic [DATA_W-1:0] stat);
		if (stat[STAT_BUSY] !== exp_busy || stat[STAT_DONE] !== exp_done ||
				stat[STAT_ERR] !== exp_err) begin
			$display("FAILED t=%0t status busy,done,error expected %b,%b,%b got %b,%b,%b",
				$time, exp_busy, exp_done, exp_err,
				stat[STAT_BUSY], stat[STAT_DONE], stat[STAT_ERR]);
			val_errs++;
		end
	endtask

	function automatic logic [DATA_W-1:0] cmd_word(input logic [3:0] op,
			input logic [ADDR_W-1:0] addr);
		cmd_word = '0;
		cmd_word[CMD_OP_LSB +: 4] = op;
		cmd_word[ADDR_W-1:0] = addr;
	endfunction

	task automatic csr_write(input logic [9:0] off, input logic [DATA_W-1:0] val);
		@(negedge sys_clk);
		csr_a = {CSR_BASE, off};
		csr_di = val;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	// read data is registered, sampled one falling edge later
	task automatic csr_read(input logic [9:0] off, output logic [DATA_W-1:0] val);
		@(negedge sys_clk);
		csr_a = {CSR_BASE, off};
		csr_we = 1'b0;
		@(negedge sys_clk);
		val = csr_do;
	endtask

	// each status poll costs two cycles
	task automatic wait_done(output logic ok);
		logic [DATA_W-1:0] stat;
		int n;
		ok = 1'b0;
		for (n = 0; n < POLL_MAX && !ok; n += 2) begin
			csr_read(CSR_STATUS, stat);
			ok = stat[STAT_DONE];
		end
		if (!ok) begin
			$display("command never completed within %0d cycles", POLL_MAX);
			other_errs++;
		end
	endtask

	task automatic run_cmd(input logic [3:0] op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic exp_err,
			output logic [DATA_W-1:0] res);
		logic [DATA_W-1:0] word;
		logic ok;
		csr_write(CSR_DATA, data);
		csr_write(CSR_CMD, cmd_word(op, addr));
		wait_done(ok);
		// handshake has wound down by now
		csr_read(CSR_STATUS, word);
		check_status(1'b0, 1'b1, exp_err, word);
		check_word("irq_o", 32'd1, 32'(irq));
		csr_read(CSR_RESULT, res);
		// data register echoes the last word written
		csr_read(CSR_DATA, word);
		check_word("csr_data", data, word);
		csr_write(CSR_STATUS, 32'd1 << STAT_DONE);
		check_word("irq_o", 32'd0, 32'(irq));
	endtask

	// expected result from the RAM model, timer reads only have to advance
	task automatic run_vector(input logic [3:0] op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic exp_err);
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] exp;
		logic [RAM_DEPTH_LOG2-1:0] idx;
		idx = addr[RAM_DEPTH_LOG2-1:0];
		run_cmd(op, addr, data, exp_err, res);
		if (exp_err) begin
			check_word("result", '0, res);
		end else if (addr[ADDR_W-1]) begin
			if (op == OP_WRITE) begin
				tmr_prev = '0;
			end else if (res <= tmr_prev) begin
				$display("timer read %h did not advance past %h", res, tmr_prev);
				other_errs++;
			end else begin
				tmr_prev = res;
			end
		end else if (op == OP_WRITE) begin
			model[idx] = data;
		end else begin
			exp = model[idx];
			if (op == OP_ADD) begin
				exp = exp + data;
				model[idx] = exp;
			end
			check_word("result", exp, res);
		end
	endtask

	// second CMD write lands while the first is outstanding
	task automatic busy_drop();
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] stat;
		logic ok;
		csr_write(CSR_DATA, 32'h0bad0bad);
		csr_write(CSR_CMD, cmd_word(OP_READ, 10'h005));
		csr_read(CSR_STATUS, stat);
		check_status(1'b1, 1'b0, 1'b0, stat);
		csr_write(CSR_CMD, cmd_word(OP_WRITE, 10'h0ff));
		wait_done(ok);
		csr_read(CSR_RESULT, res);
		check_word("result", model[5], res);
		csr_write(CSR_STATUS, 32'd1 << STAT_DONE);
		// 0ff still holds the model value
		run_vector(OP_READ, 10'h0ff, '0, 1'b0);
	endtask

	initial begin
		logic [DATA_W-1:0] rnd_addr;
		logic [DATA_W-1:0] rnd_data;
		seed = 32'h54a9;
		arst_n = 1'b0;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		tmr_prev = '0;
		// unused slots stay all ones and end the list
		for (int i = 0; i < 4*MAX_VEC; i++)
			vec[i] = '1;
		$readmemh("verif/softusb_input.txt", vec);
		nvec = 0;
		while (nvec < MAX_VEC && vec[4*nvec] !== '1)
			nvec++;
		cycle_limit = 64 * (nvec + 2*N_RAND + 2) + 200;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n = 1'b1;
		for (int i = 0; i < nvec; i++)
			run_vector(vec[4*i][3:0], vec[4*i+1][ADDR_W-1:0], vec[4*i+2], vec[4*i+3][0]);
		for (int i = 0; i < N_RAND; i++) begin
			rnd_addr = $random(seed);
			rnd_data = $random(seed);
			run_vector(OP_WRITE, {2'b00, rnd_addr[7:0]}, rnd_data, 1'b0);
			run_vector(OP_READ, {2'b00, rnd_addr[7:0]}, '0, 1'b0);
		end
		busy_drop();
		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs + other_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verif/softusb_input.txt */
// columns: opcode (1 read, 2 write, 3 add), word address, data, expected error flag
// address bit 9 selects the timer, RAM addresses 100 to 1ff are beyond the RAM
2 005 12345678 0
1 005 00000000 0
2 0ff cafef00d 0
1 0ff 00000000 0
3 005 00000011 0
1 005 00000000 0
2 010 ffffffff 0
3 010 00000002 0
1 010 00000000 0
0 005 00000000 1
7 020 00000000 1
3 200 00000001 1
1 100 00000000 1
2 1ff 5a5a5a5a 1
1 005 00000000 0
2 200 00000000 0
1 200 00000000 0
1 200 00000000 0

/* flist.f */
logic/softusb_pkg.sv
logic/softusb_cmd_if.sv
logic/softusb_bus_if.sv
logic/softusb_cmd_decode.sv
logic/softusb_engine.sv
logic/softusb_result.sv
logic/softusb_ram.sv
logic/softusb_timer.sv
logic/softusb.sv
verif/tb_softusb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_softusb -o tb_softusb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_softusb)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation returned status $rc"
	exit 1
fi
grep -qF "*** TEST PASSED ***" <<< "$out" || exit 1
